// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --assert -Wno-fatal -j 0
TOP      = tb_x86_decoder
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "run ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/dec_pkg.sv ====
package dec_pkg;

    typedef enum logic [2:0] {
        K_NONE,
        K_REG,
        K_MEM,
        K_ABS,
        K_IMM,
        K_REL
    } opnd_kind_e;

    // data is the displacement, absolute address, immediate or target
    typedef struct packed {
        opnd_kind_e                     kind;
        x86_isa_pkg::gpr_e              base;
        logic [x86_isa_pkg::ADDR_W-1:0] data;
    } operand_t;

    localparam operand_t OPND_NONE = '{kind: K_NONE, base: x86_isa_pkg::EAX, data: '0};

    // what the opcode byte alone tells about an instruction
    typedef struct packed {
        x86_isa_pkg::opcode_e opcode;
        logic                 has_modrm;
        logic [2:0]           imm_bytes;
        logic                 rm_is_dst;
        logic                 group_from_reg;
        operand_t             dst;
        operand_t             src;
    } opclass_t;

    // one decoded instruction
    typedef struct packed {
        logic [x86_isa_pkg::ADDR_W-1:0] addr;
        logic [x86_isa_pkg::LEN_W-1:0]  len;
        x86_isa_pkg::opcode_e           opcode;
        operand_t                       dst;
        operand_t                       src;
    } ins_rec_t;

endpackage

// ==== common/x86_isa_pkg.sv ====
package x86_isa_pkg;

    // address and data width of the stream
    localparam int ADDR_W      = 32;
    // start address bytes at the head of the stream, little-endian
    localparam int ADDR_BYTES  = 4;
    localparam int LEN_W       = 4;
    // operand and displacement size when not a byte form
    localparam int DWORD_BYTES = 4;

    // ALU ops first, their order follows opcode bits 5:3
    // inc, dec, push, pop follow as 8 to 11, matching opcode bits 4:3
    typedef enum logic [4:0] {
        OP_ADD,
        OP_OR,
        OP_ADC,
        OP_SBB,
        OP_AND,
        OP_SUB,
        OP_XOR,
        OP_CMP,
        OP_INC,
        OP_DEC,
        OP_PUSH,
        OP_POP,
        OP_MOV,
        OP_XCHG,
        OP_NOP,
        OP_CALL,
        OP_HLT,
        OP_BAD
    } opcode_e;

    // general registers in encoding order
    typedef enum logic [2:0] {
        EAX,
        ECX,
        EDX,
        EBX,
        ESP,
        EBP,
        ESI,
        EDI
    } gpr_e;

    // ALU operation from a 3-bit field, opcode bits 5:3 or ModR/M reg
    function automatic opcode_e alu_op(input logic [2:0] sel);
        return opcode_e'({2'b00, sel});
    endfunction

endpackage

// ==== decode/field_collector.sv ====
`timescale 1ns/1ps

module field_collector (
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  logic                 i_byte_valid,
    input  logic [7:0]           i_byte,
    output logic                 o_byte_ready,
    output logic [7:0]           o_opcode_byte,
    input  dec_pkg::opclass_t    i_class,
    output logic [7:0]           o_modrm,
    output dec_pkg::opclass_t    o_class,
    input  dec_pkg::operand_t    i_dst,
    input  dec_pkg::operand_t    i_src,
    input  logic                 i_needs_sib,
    input  logic [2:0]           i_disp_bytes,
    input  x86_isa_pkg::opcode_e i_mod_opcode,
    output logic                 o_rec_valid,
    output dec_pkg::ins_rec_t    o_rec,
    input  logic                 i_rec_ready
);
    import x86_isa_pkg::*;
    import dec_pkg::*;

    typedef enum logic [2:0] {
        ST_ADDR,
        ST_OPCODE,
        ST_MODRM,
        ST_DISP,
        ST_IMM,
        ST_HOLD
    } state_e;

    state_e            state;
    state_e            state_d;
    logic              ready_q;
    logic [1:0]        cnt;
    logic [1:0]        cnt_d;
    logic [2:0]        need;
    logic [2:0]        need_d;
    logic [LEN_W-1:0]  len;
    logic [LEN_W-1:0]  len_d;
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] addr_d;
    logic [ADDR_W-1:0] acc;
    logic [ADDR_W-1:0] value;
    opclass_t          cls;
    opcode_e           opcode;
    opcode_e           opcode_d;
    operand_t          dst;
    operand_t          dst_d;
    operand_t          src;
    operand_t          src_d;
    logic              byte_fire;
    logic              last;
    logic              done;
    logic              rec_fire;

    assign o_byte_ready  = ready_q;
    assign o_opcode_byte = i_byte;
    assign o_modrm       = i_byte;
    assign o_class       = cls;

    assign byte_fire = i_byte_valid && ready_q;
    // final byte of a displacement or immediate
    assign last = ({1'b0, cnt} == need - 3'd1);
    // little-endian field, sign-extended when only one byte long
    assign value = (need == 3'd1) ? {{(ADDR_W-8){i_byte[7]}}, i_byte}
                                  : {i_byte, acc[ADDR_W-1:8]};

    always_comb begin
        state_d  = state;
        cnt_d    = cnt;
        need_d   = need;
        len_d    = len;
        addr_d   = addr;
        opcode_d = opcode;
        dst_d    = dst;
        src_d    = src;
        done     = 1'b0;
        if (byte_fire) begin
            cnt_d = cnt + 2'd1;
            if (state != ST_ADDR) begin
                len_d = len + LEN_W'(1);
            end
            case (state)
                ST_ADDR: begin
                    addr_d = {i_byte, addr[ADDR_W-1:8]};
                    if (cnt == 2'(ADDR_BYTES - 1)) begin
                        state_d = ST_OPCODE;
                    end
                end
                ST_OPCODE: begin
                    opcode_d = i_class.opcode;
                    dst_d    = i_class.dst;
                    src_d    = i_class.src;
                    cnt_d    = '0;
                    need_d   = i_class.imm_bytes;
                    if (i_class.has_modrm) begin
                        state_d = ST_MODRM;
                    end else if (i_class.imm_bytes != 3'd0) begin
                        state_d = ST_IMM;
                    end else begin
                        done = 1'b1;
                    end
                end
                ST_MODRM: begin
                    opcode_d = i_mod_opcode;
                    dst_d    = i_dst;
                    src_d    = i_src;
                    cnt_d    = '0;
                    if (i_needs_sib) begin
                        opcode_d = OP_BAD;
                        dst_d    = OPND_NONE;
                        src_d    = OPND_NONE;
                        done     = 1'b1;
                    end else if (i_disp_bytes != 3'd0) begin
                        need_d  = i_disp_bytes;
                        state_d = ST_DISP;
                    end else if (cls.imm_bytes != 3'd0) begin
                        state_d = ST_IMM;
                    end else begin
                        done = 1'b1;
                    end
                end
                ST_DISP: begin
                    if (last) begin
                        cnt_d  = '0;
                        need_d = cls.imm_bytes;
                        // displacement belongs to whichever side is memory
                        if (dst.kind inside {K_MEM, K_ABS}) begin
                            dst_d.data = value;
                        end else begin
                            src_d.data = value;
                        end
                        if (cls.imm_bytes != 3'd0) begin
                            state_d = ST_IMM;
                        end else begin
                            done = 1'b1;
                        end
                    end
                end
                ST_IMM: begin
                    if (last) begin
                        // call keeps its rel32 in the destination
                        if (dst.kind == K_REL) begin
                            dst_d.data = value;
                        end else begin
                            src_d.data = value;
                        end
                        done = 1'b1;
                    end
                end
                default: begin
                    state_d = state;
                end
            endcase
        end
        if (done) begin
            state_d = i_rec_ready ? ST_OPCODE : ST_HOLD;
        end else if (state == ST_HOLD && i_rec_ready) begin
            state_d = ST_OPCODE;
        end
    end

    // record leaves on the same edge as its last byte, or later from hold
    assign o_rec_valid = done || (state == ST_HOLD);
    assign o_rec       = '{addr: addr, len: len_d, opcode: opcode_d, dst: dst_d, src: src_d};
    assign rec_fire    = o_rec_valid && i_rec_ready;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state   <= ST_ADDR;
            ready_q <= 1'b0;
            cnt     <= '0;
            need    <= '0;
            len     <= '0;
        end else begin
            state   <= state_d;
            ready_q <= (state_d != ST_HOLD);
            cnt     <= cnt_d;
            need    <= need_d;
            len     <= rec_fire ? '0 : len_d;
        end
    end

    always_ff @(posedge clk) begin
        // next instruction starts right after the one just sent
        addr   <= rec_fire ? addr + ADDR_W'(len_d) : addr_d;
        opcode <= opcode_d;
        dst    <= dst_d;
        src    <= src_d;
        if (byte_fire) begin
            acc <= {i_byte, acc[ADDR_W-1:8]};
        end
        if (byte_fire && state == ST_OPCODE) begin
            cls <= i_class;
        end
    end

endmodule

// ==== decode/modrm_decoder.sv ====
`timescale 1ns/1ps

module modrm_decoder (
    input  logic [7:0]           i_modrm,
    input  dec_pkg::opclass_t    i_class,
    output dec_pkg::operand_t    o_dst,
    output dec_pkg::operand_t    o_src,
    output logic                 o_needs_sib,
    output logic [2:0]           o_disp_bytes,
    output x86_isa_pkg::opcode_e o_opcode
);
    import x86_isa_pkg::*;
    import dec_pkg::*;

    logic [1:0] md;
    logic [2:0] reg_f;
    logic [2:0] rm_f;
    operand_t   reg_opnd;
    operand_t   rm_opnd;

    assign md    = i_modrm[7:6];
    assign reg_f = i_modrm[5:3];
    assign rm_f  = i_modrm[2:0];

    assign reg_opnd = '{kind: K_REG, base: gpr_e'(reg_f), data: '0};

    // rm 100 with a memory mod selects a SIB byte
    assign o_needs_sib = (md != 2'b11) && (rm_f == 3'b100);

    // r/m operand, displacement is filled in by the collector
    always_comb begin
        rm_opnd      = '{kind: K_MEM, base: gpr_e'(rm_f), data: '0};
        o_disp_bytes = 3'd0;
        case (md)
            2'b00: begin
                if (rm_f == 3'b101) begin
                    // absolute disp32, no base register
                    rm_opnd.kind = K_ABS;
                    rm_opnd.base = EAX;
                    o_disp_bytes = 3'(DWORD_BYTES);
                end
            end
            2'b01: o_disp_bytes = 3'd1;
            2'b10: o_disp_bytes = 3'(DWORD_BYTES);
            default: rm_opnd.kind = K_REG;
        endcase
    end

    always_comb begin
        if (i_class.group_from_reg) begin
            o_opcode = alu_op(reg_f);
            o_dst    = rm_opnd;
            o_src    = '{kind: K_IMM, base: EAX, data: '0};
        end else begin
            o_opcode = i_class.opcode;
            o_dst    = i_class.rm_is_dst ? rm_opnd : reg_opnd;
            o_src    = i_class.rm_is_dst ? reg_opnd : rm_opnd;
        end
    end

endmodule

// ==== decode/opcode_classifier.sv ====
`timescale 1ns/1ps

module opcode_classifier (
    input  logic [7:0]        i_opcode,
    output dec_pkg::opclass_t o_class
);
    import x86_isa_pkg::*;
    import dec_pkg::*;

    // register named by the low three opcode bits
    operand_t low_reg;

    assign low_reg = '{kind: K_REG, base: gpr_e'(i_opcode[2:0]), data: '0};

    always_comb begin
        o_class = '{opcode: OP_BAD, has_modrm: 1'b0, imm_bytes: 3'd0, rm_is_dst: 1'b0,
                    group_from_reg: 1'b0, dst: OPND_NONE, src: OPND_NONE};
        casez (i_opcode)
            8'b00??_????: begin
                // low bits 6 and 7 are segment ops, bcd adjusts and prefixes
                if (i_opcode[2:1] != 2'b11) begin
                    o_class.opcode = alu_op(i_opcode[5:3]);
                    if (i_opcode[2]) begin
                        // accumulator with an immediate sized by bit 0
                        o_class.dst       = '{kind: K_REG, base: EAX, data: '0};
                        o_class.src       = '{kind: K_IMM, base: EAX, data: '0};
                        o_class.imm_bytes = i_opcode[0] ? 3'(DWORD_BYTES) : 3'd1;
                    end else begin
                        // bit 1 set means reg is the destination
                        o_class.has_modrm = 1'b1;
                        o_class.rm_is_dst = ~i_opcode[1];
                    end
                end
            end
            8'b010?_????: begin
                o_class.opcode = opcode_e'({3'b010, i_opcode[4:3]});
                o_class.dst    = low_reg;
            end
            8'b1000_00??: begin
                // real operation comes later from the reg field
                o_class.opcode         = OP_ADD;
                o_class.has_modrm      = 1'b1;
                o_class.rm_is_dst      = 1'b1;
                o_class.group_from_reg = 1'b1;
                // only 81 carries a full imm32 and 83 sign-extends an imm8
                o_class.imm_bytes = (i_opcode[1:0] == 2'b01) ? 3'(DWORD_BYTES) : 3'd1;
            end
            8'b1000_10??: begin
                o_class.opcode    = OP_MOV;
                o_class.has_modrm = 1'b1;
                o_class.rm_is_dst = ~i_opcode[1];
            end
            8'b1001_0???: begin
                if (i_opcode[2:0] == 3'd0) begin
                    o_class.opcode = OP_NOP;
                end else begin
                    o_class.opcode = OP_XCHG;
                    o_class.dst    = low_reg;
                    o_class.src    = '{kind: K_REG, base: EAX, data: '0};
                end
            end
            8'he8: begin
                // rel32 lands in the destination and is fixed up in the resolver
                o_class.opcode    = OP_CALL;
                o_class.dst       = '{kind: K_REL, base: EAX, data: '0};
                o_class.imm_bytes = 3'(DWORD_BYTES);
            end
            8'hf4: begin
                o_class.opcode = OP_HLT;
            end
            default: begin
                o_class.opcode = OP_BAD;
            end
        endcase
    end

endmodule

// ==== decode/record_resolver.sv ====
`timescale 1ns/1ps

module record_resolver (
    input  logic              clk,
    input  logic              i_arst_n,
    input  logic              i_rec_valid,
    input  dec_pkg::ins_rec_t i_rec,
    output logic              o_rec_ready,
    output logic              o_ins_valid,
    output dec_pkg::ins_rec_t o_ins,
    input  logic              i_ins_ready
);
    import x86_isa_pkg::*;
    import dec_pkg::*;

    logic     valid_q;
    logic     load;
    ins_rec_t fixed;

    // relative target is measured from the end of the instruction
    function automatic operand_t fix_rel(input operand_t op, input ins_rec_t rec);
        operand_t res;
        res = op;
        if (op.kind == K_REL) begin
            res.data = op.data + rec.addr + ADDR_W'(rec.len);
        end
        return res;
    endfunction

    // free when empty or emptied this cycle
    assign o_rec_ready = !valid_q || i_ins_ready;
    assign load        = i_rec_valid && o_rec_ready;
    assign o_ins_valid = valid_q;

    always_comb begin
        fixed     = i_rec;
        fixed.dst = fix_rel(i_rec.dst, i_rec);
        fixed.src = fix_rel(i_rec.src, i_rec);
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (i_ins_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            o_ins <= fixed;
        end
    end

endmodule

// ==== dv/decoder_stimulus.txt ====
# B count bytes: input bytes in hex, the first line is the start address (little-endian)
# E addr len opcode dst_kind dst_reg dst_data src_kind src_reg src_data (data in hex)
B 4 00 10 40 00
B 2 01 D8
E 00401000 2 0 1 0 00000000 1 3 00000000
B 2 2B CA
E 00401002 2 5 1 1 00000000 1 2 00000000
B 2 89 E5
E 00401004 2 12 1 5 00000000 1 4 00000000
B 3 8B 45 F8
E 00401006 3 12 1 0 00000000 2 5 FFFFFFF8
B 6 89 8E 00 01 00 00
E 00401009 6 12 2 6 00000100 1 1 00000000
B 6 8B 0D 78 56 34 12
E 0040100F 6 12 1 1 00000000 3 0 12345678
B 5 05 44 33 22 11
E 00401015 5 0 1 0 00000000 4 0 11223344
B 3 83 C0 FF
E 0040101A 3 0 1 0 00000000 4 0 FFFFFFFF
B 7 81 7D 08 00 10 00 00
E 0040101D 7 7 2 5 00000008 4 0 00001000
B 3 80 F1 7F
E 00401024 3 6 1 1 00000000 4 0 0000007F
B 1 40
E 00401027 1 8 1 0 00000000 0 0 00000000
B 1 4F
E 00401028 1 9 1 7 00000000 0 0 00000000
B 1 55
E 00401029 1 10 1 5 00000000 0 0 00000000
B 1 5E
E 0040102A 1 11 1 6 00000000 0 0 00000000
B 1 90
E 0040102B 1 14 0 0 00000000 0 0 00000000
B 1 93
E 0040102C 1 13 1 3 00000000 1 0 00000000
B 5 E8 10 00 00 00
E 0040102D 5 15 5 0 00401042 0 0 00000000
B 5 E8 F0 FF FF FF
E 00401032 5 15 5 0 00401027 0 0 00000000
B 1 66
E 00401037 1 17 0 0 00000000 0 0 00000000
B 1 0F
E 00401038 1 17 0 0 00000000 0 0 00000000
B 2 01 04
E 00401039 2 17 0 0 00000000 0 0 00000000
B 2 31 C0
E 0040103B 2 6 1 0 00000000 1 0 00000000
B 3 00 59 FC
E 0040103D 3 0 2 1 FFFFFFFC 1 3 00000000
B 2 8B 03
E 00401040 2 12 1 0 00000000 2 3 00000000
B 1 F4
E 00401042 1 16 0 0 00000000 0 0 00000000

// ==== dv/tb_x86_decoder.sv ====
`timescale 1ns/1ps

module tb_x86_decoder;
    import x86_isa_pkg::*;
    import dec_pkg::*;

    localparam int          CLK_HALF     = 4;
    localparam int          DRIVE_DLY    = 1;
    localparam int          RESET_CYCLES = 8;
    localparam logic [31:0] SEED         = 32'hfbce_5d2f;
    localparam string       STIM_FILE    = "dv/decoder_stimulus.txt";

    logic     clk;
    logic     i_arst_n;
    logic     i_byte_valid;
    logic [7:0] i_byte;
    logic     o_byte_ready;
    logic     o_ins_valid;
    ins_rec_t o_ins;
    logic     i_ins_ready;

    logic [7:0]  byte_q [$];
    ins_rec_t    exp_q [$];
    int          n_recv;
    int          mismatches;
    int          other_errs;
    int          cycles;
    int          cycle_limit = 200;
    bit          load_ok;
    logic [31:0] next_addr;

    x86_decoder DUT (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_byte_valid(i_byte_valid),
        .i_byte      (i_byte),
        .o_byte_ready(o_byte_ready),
        .o_ins_valid (o_ins_valid),
        .o_ins       (o_ins),
        .i_ins_ready (i_ins_ready)
    );

    always #CLK_HALF clk = ~clk;

    function automatic operand_t make_opnd(input int kind, input int base,
                                           input logic [31:0] data);
        operand_t op;
        op.kind = opnd_kind_e'(kind[2:0]);
        op.base = gpr_e'(base[2:0]);
        op.data = data;
        return op;
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            mismatches++;
            $display("error: %s expected %08h actual %08h", what, exp, act);
        end
    endtask

    task automatic check_record(input int idx, input ins_rec_t exp, input ins_rec_t act);
        string tag;
        tag = $sformatf("record %0d at %08h", idx, exp.addr);
        check_val({tag, " addr"}, exp.addr, act.addr);
        check_val({tag, " len"}, 32'(exp.len), 32'(act.len));
        check_val({tag, " opcode"}, 32'(exp.opcode), 32'(act.opcode));
        check_val({tag, " dst.kind"}, 32'(exp.dst.kind), 32'(act.dst.kind));
        check_val({tag, " dst.base"}, 32'(exp.dst.base), 32'(act.dst.base));
        check_val({tag, " dst.data"}, exp.dst.data, act.dst.data);
        check_val({tag, " src.kind"}, 32'(exp.src.kind), 32'(act.src.kind));
        check_val({tag, " src.base"}, 32'(exp.src.base), 32'(act.src.base));
        check_val({tag, " src.data"}, exp.src.data, act.src.data);
    endtask

    // B lines carry a byte count and the bytes
    // E lines carry one expected record
    task automatic load_stimulus();
        int          fd;
        int          ch;
        int          r;
        int          nb;
        int          k;
        bit          bad;
        logic [31:0] val;
        logic [31:0] e_addr;
        logic [31:0] dd;
        logic [31:0] sd;
        int          e_len;
        int          e_op;
        int          dk;
        int          dr;
        int          sk;
        int          sr;
        ins_rec_t    rec;
        bad = 1'b0;
        fd  = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            bad = 1'b1;
            $display("could not open the stimulus file %s", STIM_FILE);
        end else begin
            ch = $fgetc(fd);
            while (ch != -1) begin
                case (8'(ch))
                    "B": begin
                        r = $fscanf(fd, " %d", nb);
                        if (r != 1) begin
                            bad = 1'b1;
                        end
                        for (k = 0; k < nb; k++) begin
                            r = $fscanf(fd, " %h", val);
                            if (r != 1) begin
                                bad = 1'b1;
                            end
                            byte_q.push_back(val[7:0]);
                        end
                    end
                    "E": begin
                        r = $fscanf(fd, " %h %d %d %d %d %h %d %d %h",
                                    e_addr, e_len, e_op, dk, dr, dd, sk, sr, sd);
                        if (r != 9) begin
                            bad = 1'b1;
                        end
                        rec.addr   = e_addr;
                        rec.len    = e_len[LEN_W-1:0];
                        rec.opcode = opcode_e'(e_op[4:0]);
                        rec.dst    = make_opnd(dk, dr, dd);
                        rec.src    = make_opnd(sk, sr, sd);
                        exp_q.push_back(rec);
                    end
                    "#": begin
                        while (ch != -1 && ch != 10) begin
                            ch = $fgetc(fd);
                        end
                    end
                    default: begin
                    end
                endcase
                ch = $fgetc(fd);
            end
            $fclose(fd);
        end
        cycle_limit = 20 * byte_q.size() + 200;
        load_ok = !bad && (byte_q.size() > ADDR_BYTES) && (exp_q.size() > 0);
        if (!load_ok) begin
            other_errs++;
            $display("stimulus file is missing, empty or malformed");
        end
    endtask

    // random idle cycles between bytes
    task automatic send_bytes();
        int i;
        for (i = 0; i < byte_q.size(); i++) begin
            if ($urandom_range(3) == 0) begin
                i_byte_valid = 1'b0;
                repeat (1 + $urandom_range(2)) @(posedge clk);
                #DRIVE_DLY;
            end
            i_byte_valid = 1'b1;
            i_byte       = byte_q[i];
            // ready seen at the negedge means transfer on the next rising edge
            @(negedge clk);
            while (!o_byte_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
            #DRIVE_DLY;
        end
        i_byte_valid = 1'b0;
    endtask

    // random back-pressure on the record output
    initial begin
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            i_ins_ready = ($urandom_range(3) != 0);
        end
    end

    // record is stable at the negedge and taken on the next edge
    always @(negedge clk) begin
        if (i_arst_n && o_ins_valid && i_ins_ready) begin
            if (n_recv >= exp_q.size()) begin
                other_errs++;
                $display("extra record at address %08h beyond the expected list", o_ins.addr);
            end else begin
                if (n_recv == 0) begin
                    next_addr = {byte_q[3], byte_q[2], byte_q[1], byte_q[0]};
                end
                check_val($sformatf("record %0d address chain", n_recv), next_addr, o_ins.addr);
                check_record(n_recv, exp_q[n_recv], o_ins);
                next_addr = next_addr + 32'(exp_q[n_recv].len);
            end
            n_recv++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d records received",
                     cycles, n_recv, exp_q.size());
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        i_arst_n     = 1'b0;
        i_byte_valid = 1'b0;
        i_byte       = 8'h00;
        i_ins_ready  = 1'b0;
        void'($urandom(SEED));
        load_stimulus();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        i_arst_n = 1'b1;
        if (load_ok) begin
            send_bytes();
            while (n_recv < exp_q.size()) begin
                @(posedge clk);
            end
            // extra cycles so a duplicated record still shows up
            repeat (20) @(posedge clk);
        end
        $display("checked %0d of %0d records with %0d mismatches and %0d other errors",
                 n_recv, exp_q.size(), mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== dv/x86_decoder_asserts.sv ====
`timescale 1ns/1ps

module x86_decoder_asserts (
    input logic              clk,
    input logic              i_arst_n,
    input logic              o_byte_ready,
    input logic              o_ins_valid,
    input dec_pkg::ins_rec_t o_ins,
    input logic              i_ins_ready
);

    // stalled record keeps valid and its value until taken
    property p_hold_stalled;
        @(posedge clk) disable iff (!i_arst_n)
            (o_ins_valid && !i_ins_ready) |=> (o_ins_valid && $stable(o_ins));
    endproperty

    a_hold_stalled: assert property (p_hold_stalled)
        else $error("record changed or dropped while the output was stalled");

    a_reset_quiet: assert property (@(posedge clk) !i_arst_n |-> (!o_ins_valid && !o_byte_ready))
        else $error("handshake outputs active during reset");

    // every record covers at least its opcode byte
    a_len_nonzero: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_ins_valid |-> (o_ins.len != '0))
        else $error("record presented with length zero");

endmodule

bind x86_decoder x86_decoder_asserts u_asserts (.*);

// ==== hw/x86_decoder.sv ====
`timescale 1ns/1ps

module x86_decoder (
    input  logic              clk,
    input  logic              i_arst_n,
    input  logic              i_byte_valid,
    input  logic [7:0]        i_byte,
    output logic              o_byte_ready,
    output logic              o_ins_valid,
    output dec_pkg::ins_rec_t o_ins,
    input  logic              i_ins_ready
);
    import x86_isa_pkg::*;
    import dec_pkg::*;

    logic [7:0] opcode_byte;
    logic [7:0] modrm_byte;
    opclass_t   byte_class;
    opclass_t   latched_class;
    operand_t   mod_dst;
    operand_t   mod_src;
    logic       needs_sib;
    logic [2:0] disp_bytes;
    opcode_e    mod_opcode;
    logic       rec_valid;
    logic       rec_ready;
    ins_rec_t   rec;

    field_collector u_collector (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_byte_valid (i_byte_valid),
        .i_byte       (i_byte),
        .o_byte_ready (o_byte_ready),
        .o_opcode_byte(opcode_byte),
        .i_class      (byte_class),
        .o_modrm      (modrm_byte),
        .o_class      (latched_class),
        .i_dst        (mod_dst),
        .i_src        (mod_src),
        .i_needs_sib  (needs_sib),
        .i_disp_bytes (disp_bytes),
        .i_mod_opcode (mod_opcode),
        .o_rec_valid  (rec_valid),
        .o_rec        (rec),
        .i_rec_ready  (rec_ready)
    );

    opcode_classifier u_classifier (
        .i_opcode(opcode_byte),
        .o_class (byte_class)
    );

    modrm_decoder u_modrm (
        .i_modrm     (modrm_byte),
        .i_class     (latched_class),
        .o_dst       (mod_dst),
        .o_src       (mod_src),
        .o_needs_sib (needs_sib),
        .o_disp_bytes(disp_bytes),
        .o_opcode    (mod_opcode)
    );

    record_resolver u_resolver (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_rec_valid(rec_valid),
        .i_rec      (rec),
        .o_rec_ready(rec_ready),
        .o_ins_valid(o_ins_valid),
        .o_ins      (o_ins),
        .i_ins_ready(i_ins_ready)
    );

endmodule

// ==== sources.f ====
common/x86_isa_pkg.sv
common/dec_pkg.sv
decode/opcode_classifier.sv
decode/modrm_decoder.sv
decode/field_collector.sv
decode/record_resolver.sv
hw/x86_decoder.sv
dv/x86_decoder_asserts.sv
dv/tb_x86_decoder.sv
